// File: serv_defs.svh
`ifndef SERV_DEFS_SVH
`define SERV_DEFS_SVH

// Data path width in bits.
`define XLEN 32

// Word address width of the shared RAM.
`define ADDR_W 8
`define RAM_WORDS 256

// Byte address of the first instruction fetched after reset.
`define RESET_PC 32'h0000_0000

`define CNT_W 5 // Counts the 32 serial bit cycles.

`endif

// File: rv_isa_pkg.sv
`include "serv_defs.svh"

package rv_isa_pkg;

   typedef logic [`XLEN-1:0] xlen_word_t;
   typedef logic [4:0]       reg_idx_t;
   typedef logic [6:0]       opcode_t;
   typedef logic [2:0]       funct3_t;

   typedef enum logic [2:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR
   } alu_op_e;

   // Major opcodes of the supported RV32I subset.
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_OPIMM  = 7'b0010011;
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_STORE  = 7'b0100011;
   localparam opcode_t OPC_BRANCH = 7'b1100011;
   localparam opcode_t OPC_JAL    = 7'b1101111;

   localparam funct3_t F3_ADD = 3'b000; // ADD and SUB share this code.
   localparam funct3_t F3_XOR = 3'b100;
   localparam funct3_t F3_OR  = 3'b110;
   localparam funct3_t F3_AND = 3'b111;
   localparam funct3_t F3_BEQ = 3'b000;
   localparam funct3_t F3_BNE = 3'b001;

endpackage

// File: bus_pkg.sv
`include "serv_defs.svh"

package bus_pkg;

   import rv_isa_pkg::*;

   typedef logic [`ADDR_W-1:0] word_addr_t;

   typedef struct packed {
      logic       we;
      word_addr_t addr;
      xlen_word_t wdata;
   } bus_req_t;

   typedef struct packed {
      xlen_word_t rdata; // Old word at the address, for writes too.
   } bus_rsp_t;

   // Which requester owns the RAM while its response is outstanding.
   typedef enum logic [1:0] {IDLE, HOST, DATA, FETCH} grant_e;

endpackage

// File: serial_alu.sv
module serial_alu import rv_isa_pkg::*; (
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_init,
   input  alu_op_e i_op,
   input  logic    i_a,
   input  logic    i_b,
   output logic    o_rd,
   output logic    o_eq
);

   logic carry_q;
   logic eq_q;
   logic b_eff;
   logic cin;
   logic sum;

   // Subtraction adds the inverted operand with a carry in of one.
   assign b_eff = i_b ^ (i_op == SUB);
   assign cin   = i_init ? (i_op == SUB) : carry_q;
   assign sum   = i_a ^ b_eff ^ cin;

   assign o_eq = (i_init | eq_q) & ~(i_a ^ i_b); // Includes the current bit pair.

   always_comb begin
      case (i_op)
         AND:     o_rd = i_a & i_b;
         OR:      o_rd = i_a | i_b;
         XOR:     o_rd = i_a ^ i_b;
         default: o_rd = sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b1;
      end else begin
         carry_q <= (i_a & b_eff) | (cin & (i_a ^ b_eff));
         eq_q    <= o_eq;
      end
   end

endmodule

// File: serial_regfile.sv
`include "serv_defs.svh"

module serial_regfile import rv_isa_pkg::*; (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic [`CNT_W-1:0] i_cnt,
   input  reg_idx_t          i_rs1_addr,
   input  reg_idx_t          i_rs2_addr,
   input  logic              i_rd_en,
   input  reg_idx_t          i_rd_addr,
   input  logic              i_rd,
   output logic              o_rs1,
   output logic              o_rs2
);

   xlen_word_t regs [32];

   // x0 is hardwired to zero.
   assign o_rs1 = (i_rs1_addr == '0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == '0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

   // One bit of rd is written per cycle.
   always_ff @(posedge clk) begin
      if (i_rd_en && (i_rd_addr != '0)) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   a_rd_addr_known : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_rd_en |-> !$isunknown(i_rd_addr)
   );

endmodule

// File: serial_core.sv
`include "serv_defs.svh"

module serial_core import rv_isa_pkg::*, bus_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_run,
   input  logic     i_fetch_ready,
   input  logic     i_fetch_rsp_valid,
   input  bus_rsp_t i_fetch_rsp,
   input  logic     i_data_ready,
   input  logic     i_data_rsp_valid,
   input  bus_rsp_t i_data_rsp,
   output logic     o_fetch_valid,
   output bus_req_t o_fetch_req,
   output logic     o_data_valid,
   output bus_req_t o_data_req,
   output logic     o_halt
);

   typedef enum logic [2:0] {IDLE, FETCH, EXEC, ADDR, MEM, LOAD, HALT} core_state_e;

   core_state_e       state_q;
   logic [`CNT_W-1:0] cnt_q;
   logic              fetch_sent_q;
   xlen_word_t        pc_q;
   xlen_word_t        instr_q;
   xlen_word_t        imm_q;
   xlen_word_t        addr_q;
   xlen_word_t        wdata_q;
   xlen_word_t        load_q;
   xlen_word_t        imm_full;
   xlen_word_t        pc_plus4;
   xlen_word_t        target;
   opcode_t           opcode;
   funct3_t           funct3;
   alu_op_e           alu_op;
   logic is_op, is_opimm, is_load, is_store, is_branch, is_jal;
   logic rs1_bit, rs2_bit, op_b, alu_rd, alu_eq;
   logic rd_bit, rd_en, last_bit, taken, halt_jump;

   function automatic xlen_word_t imm_of(input xlen_word_t ins);
      opcode_t opc;
      opc = ins[6:0];
      case (opc)
         OPC_STORE:  imm_of = {{21{ins[31]}}, ins[30:25], ins[11:7]};
         OPC_BRANCH: imm_of = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         OPC_JAL:    imm_of = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         default:    imm_of = {{21{ins[31]}}, ins[30:20]};
      endcase
   endfunction

   assign opcode    = instr_q[6:0];
   assign funct3    = instr_q[14:12];
   assign is_op     = (opcode == OPC_OP);
   assign is_opimm  = (opcode == OPC_OPIMM);
   assign is_load   = (opcode == OPC_LOAD);
   assign is_store  = (opcode == OPC_STORE);
   assign is_branch = (opcode == OPC_BRANCH);
   assign is_jal    = (opcode == OPC_JAL);

   always_comb begin
      alu_op = ADD;
      if (is_op || is_opimm) begin
         case (funct3)
            F3_ADD:  alu_op = (is_op && instr_q[30]) ? SUB : ADD;
            F3_XOR:  alu_op = XOR;
            F3_OR:   alu_op = OR;
            F3_AND:  alu_op = AND;
            default: alu_op = ADD;
         endcase
      end
   end

   // PC arithmetic stays parallel.
   assign imm_full  = imm_of(instr_q);
   assign pc_plus4  = pc_q + 32'd4;
   assign target    = pc_q + imm_full;
   assign last_bit  = (cnt_q == '1);
   assign taken     = is_branch && (funct3 == F3_BNE ? !alu_eq : alu_eq);
   assign halt_jump = is_jal && (imm_full == '0); // A jump to itself.

   assign op_b  = (is_op || is_branch) ? rs2_bit : imm_q[0];
   assign rd_en = ((state_q == EXEC) && (is_op || is_opimm || is_jal)) || (state_q == LOAD);
   assign rd_bit = (state_q == LOAD) ? load_q[cnt_q] : (is_jal ? pc_plus4[cnt_q] : alu_rd);

   serial_alu alu_i (
      .clk    (clk),
      .i_rst_n(i_rst_n),
      .i_init ((state_q == EXEC) && (cnt_q == '0)),
      .i_op   (alu_op),
      .i_a    (rs1_bit),
      .i_b    (op_b),
      .o_rd   (alu_rd),
      .o_eq   (alu_eq)
   );

   serial_regfile regfile_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_cnt     (cnt_q),
      .i_rs1_addr(instr_q[19:15]),
      .i_rs2_addr(instr_q[24:20]),
      .i_rd_en   (rd_en),
      .i_rd_addr (instr_q[11:7]),
      .i_rd      (rd_bit),
      .o_rs1     (rs1_bit),
      .o_rs2     (rs2_bit)
   );

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q      <= IDLE;
         cnt_q        <= '0;
         fetch_sent_q <= 1'b0;
         pc_q         <= `RESET_PC;
      end else begin
         case (state_q)
            IDLE: if (i_run) state_q <= FETCH;
            FETCH: begin
               if (o_fetch_valid && i_fetch_ready) fetch_sent_q <= 1'b1;
               if (i_fetch_rsp_valid) begin
                  fetch_sent_q <= 1'b0;
                  state_q      <= EXEC;
               end
            end
            EXEC: begin
               cnt_q <= cnt_q + 1'b1; // Wraps back to zero after bit 31.
               if (last_bit) begin
                  pc_q <= (is_jal || taken) ? target : pc_plus4;
                  if (halt_jump) state_q <= HALT;
                  else if (is_load || is_store) state_q <= ADDR;
                  else state_q <= FETCH;
               end
            end
            ADDR: if (i_data_ready) state_q <= MEM;
            MEM: if (i_data_rsp_valid) state_q <= is_load ? LOAD : FETCH;
            LOAD: begin
               cnt_q <= cnt_q + 1'b1;
               if (last_bit) state_q <= FETCH;
            end
            default: state_q <= state_q;
         endcase
      end
   end

   // Immediate, address and store data shift in LSB first.
   always_ff @(posedge clk) begin
      if ((state_q == FETCH) && i_fetch_rsp_valid) begin
         instr_q <= i_fetch_rsp.rdata;
         imm_q   <= imm_of(i_fetch_rsp.rdata);
      end
      if (state_q == EXEC) begin
         imm_q   <= {1'b0, imm_q[`XLEN-1:1]};
         addr_q  <= {alu_rd, addr_q[`XLEN-1:1]};
         wdata_q <= {rs2_bit, wdata_q[`XLEN-1:1]};
      end
      if ((state_q == MEM) && i_data_rsp_valid) load_q <= i_data_rsp.rdata;
   end

   assign o_fetch_valid = (state_q == FETCH) && !fetch_sent_q;
   assign o_fetch_req   = '{we: 1'b0, addr: pc_q[`ADDR_W+1:2], wdata: '0};
   assign o_data_valid  = (state_q == ADDR);
   assign o_data_req    = '{we: is_store, addr: addr_q[`ADDR_W+1:2], wdata: wdata_q};
   assign o_halt        = (state_q == HALT);

   a_one_port : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      !(o_fetch_valid && o_data_valid)
   );

endmodule

// File: mem_arbiter.sv
module mem_arbiter import bus_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_host_valid,
   input  bus_req_t i_host_req,
   input  logic     i_data_valid,
   input  bus_req_t i_data_req,
   input  logic     i_fetch_valid,
   input  bus_req_t i_fetch_req,
   input  logic     i_ram_rsp_valid,
   input  bus_rsp_t i_ram_rsp,
   output logic     o_host_ready,
   output logic     o_data_ready,
   output logic     o_fetch_ready,
   output logic     o_host_rsp_valid,
   output logic     o_data_rsp_valid,
   output logic     o_fetch_rsp_valid,
   output bus_rsp_t o_rsp,
   output logic     o_ram_valid,
   output bus_req_t o_ram_req
);

   grant_e   grant_q;
   bus_rsp_t rsp_q;
   logic     idle;

   assign idle = (grant_q == IDLE);

   // Host wins over data, data over fetch.
   assign o_host_ready  = idle && i_host_valid;
   assign o_data_ready  = idle && i_data_valid && !i_host_valid;
   assign o_fetch_ready = idle && i_fetch_valid && !i_host_valid && !i_data_valid;
   assign o_ram_valid   = o_host_ready || o_data_ready || o_fetch_ready;
   assign o_ram_req     = i_host_valid ? i_host_req : (i_data_valid ? i_data_req : i_fetch_req);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         grant_q           <= IDLE;
         o_host_rsp_valid  <= 1'b0;
         o_data_rsp_valid  <= 1'b0;
         o_fetch_rsp_valid <= 1'b0;
      end else begin
         o_host_rsp_valid  <= i_ram_rsp_valid && (grant_q == HOST);
         o_data_rsp_valid  <= i_ram_rsp_valid && (grant_q == DATA);
         o_fetch_rsp_valid <= i_ram_rsp_valid && (grant_q == FETCH);
         if (o_host_ready) grant_q <= HOST;
         else if (o_data_ready) grant_q <= DATA;
         else if (o_fetch_ready) grant_q <= FETCH;
         else if (i_ram_rsp_valid) grant_q <= IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (i_ram_rsp_valid) rsp_q <= i_ram_rsp;
   end

   assign o_rsp = rsp_q;

   a_one_ready : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      $onehot0({o_host_ready, o_data_ready, o_fetch_ready})
   );

   a_rsp_owned : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_ram_rsp_valid |-> (grant_q != IDLE)
   );

endmodule

// File: shared_ram.sv
`include "serv_defs.svh"

module shared_ram import bus_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_valid,
   input  bus_req_t i_req,
   output logic     o_rsp_valid,
   output bus_rsp_t o_rsp
);

   logic [`XLEN-1:0] mem [`RAM_WORDS];
   bus_rsp_t         rsp_q;

   // Read before write so a store also returns the old word.
   always_ff @(posedge clk) begin
      if (i_valid) begin
         rsp_q.rdata <= mem[i_req.addr];
         if (i_req.we) mem[i_req.addr] <= i_req.wdata;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rsp_valid <= 1'b0;
      end else begin
         o_rsp_valid <= i_valid;
      end
   end

   assign o_rsp = rsp_q;

endmodule

// File: cpu_subsys_top.sv
module cpu_subsys_top import bus_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_run,
   input  logic     i_host_valid,
   input  bus_req_t i_host_req,
   output logic     o_host_ready,
   output logic     o_host_rsp_valid,
   output bus_rsp_t o_host_rsp,
   output logic     o_halt
);

   logic     fetch_valid, fetch_ready, fetch_rsp_valid;
   logic     data_valid, data_ready, data_rsp_valid;
   logic     ram_valid, ram_rsp_valid;
   bus_req_t fetch_req, data_req, ram_req;
   bus_rsp_t arb_rsp, ram_rsp;

   serial_core core_i (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_run            (i_run),
      .i_fetch_ready    (fetch_ready),
      .i_fetch_rsp_valid(fetch_rsp_valid),
      .i_fetch_rsp      (arb_rsp),
      .i_data_ready     (data_ready),
      .i_data_rsp_valid (data_rsp_valid),
      .i_data_rsp       (arb_rsp),
      .o_fetch_valid    (fetch_valid),
      .o_fetch_req      (fetch_req),
      .o_data_valid     (data_valid),
      .o_data_req       (data_req),
      .o_halt           (o_halt)
   );

   mem_arbiter arbiter_i (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_host_valid     (i_host_valid),
      .i_host_req       (i_host_req),
      .i_data_valid     (data_valid),
      .i_data_req       (data_req),
      .i_fetch_valid    (fetch_valid),
      .i_fetch_req      (fetch_req),
      .i_ram_rsp_valid  (ram_rsp_valid),
      .i_ram_rsp        (ram_rsp),
      .o_host_ready     (o_host_ready),
      .o_data_ready     (data_ready),
      .o_fetch_ready    (fetch_ready),
      .o_host_rsp_valid (o_host_rsp_valid),
      .o_data_rsp_valid (data_rsp_valid),
      .o_fetch_rsp_valid(fetch_rsp_valid),
      .o_rsp            (arb_rsp), // One payload bus, qualified by the three valids.
      .o_ram_valid      (ram_valid),
      .o_ram_req        (ram_req)
   );

   shared_ram ram_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_valid    (ram_valid),
      .i_req      (ram_req),
      .o_rsp_valid(ram_rsp_valid),
      .o_rsp      (ram_rsp)
   );

   assign o_host_rsp = arb_rsp;

endmodule

// File: tb_checker.sv
module tb_checker import bus_pkg::*; (
   input  logic         clk,
   input  logic         i_rst_n,
   input  logic         i_rsp_valid,
   input  bus_rsp_t     i_rsp,
   input  logic         i_halt,
   input  logic         i_exp_armed,
   input  logic         i_exp_running,
   input  logic [255:0] i_exp_name,
   input  logic [31:0]  i_exp_word,
   output int           o_pass_cnt,
   output int           o_fail_cnt
);

   timeunit 1ns;
   timeprecision 100ps;

   int   pass_cnt  = 0;
   int   fail_cnt  = 0;
   int   programs  = 0;
   logic halt_seen = 1'b0;

   assign o_pass_cnt = pass_cnt;
   assign o_fail_cnt = fail_cnt;

   // Host responses are compared against the expectation that tb_top armed.
   always @(posedge clk) begin
      if (i_rsp_valid && i_exp_armed) begin
         if (i_rsp.rdata !== i_exp_word) begin
            $display("ERR %0s: expected %h, actual %h", i_exp_name, i_exp_word, i_rsp.rdata);
            fail_cnt = fail_cnt + 1;
         end else if (i_exp_running && i_halt) begin
            $display("%0s: the host read was only served after the core had halted",
                     i_exp_name);
            fail_cnt = fail_cnt + 1;
         end else begin
            $display("PASS %0s", i_exp_name);
            pass_cnt = pass_cnt + 1;
         end
      end
   end

   // Once a program halts, o_halt must hold until the next reset.
   always @(posedge clk) begin
      if (!i_rst_n) begin
         halt_seen = 1'b0;
      end else if (i_halt && !halt_seen) begin
         halt_seen = 1'b1;
         programs  = programs + 1;
         $display("PASS program %0d reached its self-jump", programs);
         pass_cnt = pass_cnt + 1;
      end else if (halt_seen && !i_halt) begin
         $display("Halt output dropped without a reset after program %0d", programs);
         fail_cnt  = fail_cnt + 1;
         halt_seen = 1'b0;
      end
   end

endmodule

// File: tb_top.sv
`include "serv_defs.svh"

module tb_top import bus_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   logic               clk;
   logic               rst_n;
   logic               run;
   logic               host_valid;
   bus_req_t           host_req;
   logic               host_ready;
   logic               host_rsp_valid;
   bus_rsp_t           host_rsp;
   logic               halt;
   logic               exp_armed;
   logic               exp_running;
   logic [255:0]       exp_name;
   logic [`XLEN-1:0]   exp_word;
   int                 pass_cnt;
   int                 fail_cnt;
   int                 cycles    = 0;
   int                 limit     = 0;
   logic               limit_set = 1'b0;
   int                 fd;
   int                 n;
   string              line;
   logic [7:0]         kind;
   logic [255:0]       name;
   logic [`ADDR_W-1:0] addr;
   logic [`XLEN-1:0]   word;
   logic [`XLEN-1:0]   expv;

   cpu_subsys_top cpu_subsys_top_i (
      .clk             (clk),
      .i_rst_n         (rst_n),
      .i_run           (run),
      .i_host_valid    (host_valid),
      .i_host_req      (host_req),
      .o_host_ready    (host_ready),
      .o_host_rsp_valid(host_rsp_valid),
      .o_host_rsp      (host_rsp),
      .o_halt          (halt)
   );

   tb_checker checker_i (
      .clk          (clk),
      .i_rst_n      (rst_n),
      .i_rsp_valid  (host_rsp_valid),
      .i_rsp        (host_rsp),
      .i_halt       (halt),
      .i_exp_armed  (exp_armed),
      .i_exp_running(exp_running),
      .i_exp_name   (exp_name),
      .i_exp_word   (exp_word),
      .o_pass_cnt   (pass_cnt),
      .o_fail_cnt   (fail_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit_set && (cycles >= limit)) begin
         $display("Timeout: the tests did not finish within %0d cycles.", limit);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic apply_reset();
      @(posedge clk);
      #2;
      rst_n = 1'b0;
      run   = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
   endtask

   // One host transfer; the checker compares the response when chk is set.
   task automatic host_access(input logic we, input logic [`ADDR_W-1:0] a,
                              input logic [`XLEN-1:0] wd, input logic chk,
                              input logic running, input logic [255:0] nm,
                              input logic [`XLEN-1:0] ex);
      @(posedge clk);
      #2;
      exp_armed     = chk;
      exp_running   = running;
      exp_name      = nm;
      exp_word      = ex;
      host_req.we    = we;
      host_req.addr  = a;
      host_req.wdata = wd;
      host_valid     = 1'b1;
      @(negedge clk);
      while (!host_ready) @(negedge clk);
      @(posedge clk);
      #2;
      host_valid = 1'b0;
      @(negedge clk);
      while (!host_rsp_valid) @(negedge clk);
   endtask

   task automatic wait_for_halt();
      @(negedge clk);
      while (!halt) @(negedge clk);
   endtask

   task automatic start_core();
      apply_reset();
      @(posedge clk);
      #2;
      run = 1'b1;
   endtask

   // First pass over the golden file sizes the timeout.
   task automatic compute_limit();
      int words;
      int checks;
      words  = 0;
      checks = 0;
      fd = $fopen("cpu_golden.txt", "r");
      while (fd != 0 && !$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line[0] == 8'h23) continue;
         n = $sscanf(line, "%s %s %h %h %h", kind, name, addr, word, expv);
         if (n < 4) continue;
         if (kind == "W" || kind == "U") words = words + 1;
         if (kind == "U" || kind == "C" || kind == "P") checks = checks + 1;
      end
      if (fd != 0) $fclose(fd);
      limit     = 200 * words + 10 * checks;
      limit_set = 1'b1;
   endtask

   initial begin
      rst_n       = 1'b0;
      run         = 1'b0;
      host_valid  = 1'b0;
      host_req    = '0;
      exp_armed   = 1'b0;
      exp_running = 1'b0;
      exp_name    = '0;
      exp_word    = '0;
      compute_limit();
      fd = $fopen("cpu_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open cpu_golden.txt for reading.");
         $display("TESTS FAILED");
         $finish;
      end
      apply_reset();
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line[0] == 8'h23) continue;
         n = $sscanf(line, "%s %s %h %h %h", kind, name, addr, word, expv);
         if (n < 4) continue;
         if (n == 4) expv = word; // A short read line gives its expected word in the data column.
         case (kind)
            "W": host_access(1'b1, addr, word, 1'b0, 1'b0, name, '0);
            "U": host_access(1'b1, addr, word, 1'b1, 1'b0, name, expv);
            "C": host_access(1'b0, addr, '0, 1'b1, 1'b0, name, expv);
            "R": begin
               start_core();
               wait_for_halt();
            end
            "P": begin
               start_core(); // The host read below competes with the running core.
               @(posedge clk); // The first fetch is in flight when the host request arrives.
               host_access(1'b0, addr, '0, 1'b1, 1'b1, name, expv);
               wait_for_halt();
            end
            default: $display("Skipping golden line with unknown kind: %s", line);
         endcase
      end
      $fclose(fd);
      @(posedge clk);
      #2;
      $display("Totals: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: flist.f
+incdir+.
rv_isa_pkg.sv
bus_pkg.sv
serial_alu.sv
serial_regfile.sv
serial_core.sv
mem_arbiter.sv
shared_ram.sv
cpu_subsys_top.sv
tb_checker.sv
tb_top.sv

// File: run_sim.sh
#!/bin/bash
# Build with Verilator, run, and judge the run by the pass line in sim.log.
rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module tb_top -f flist.f > build.log 2>&1 \
   && ./obj_dir/Vtb_top > sim.log 2>&1 \
   || echo "Build or simulation run did not complete, see build.log and sim.log."
cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "Simulation passed." && exit 0 \
   || { echo "Simulation failed."; exit 1; }

// File: cpu_golden.txt
# kind name word_addr data expected  (all numbers hex, word addresses)
# W write, U write with old word checked, C read check, R run to halt, P run with host read
W - f0 11111111 0
U wr_old_word f0 a5a5a5a5 11111111
C rd_new_word f0 a5a5a5a5
W - f1 0f0f0f0f 0
C rd_second f1 0 0f0f0f0f
# Arithmetic program, results stored at 80..87
W - 00 fff00093 0
W - 01 00100113 0
W - 02 002081b3 0
W - 03 55500213 0
W - 04 80000293 0
W - 05 40520333 0
W - 06 0040f3b3 0
W - 07 00526433 0
W - 08 0040c4b3 0
W - 09 40200533 0
W - 0a faa30593 0
W - 0b 20302023 0
W - 0c 20602223 0
W - 0d 20702423 0
W - 0e 20802623 0
W - 0f 20902823 0
W - 10 20a02a23 0
W - 11 20b02c23 0
W - 12 20502e23 0
W - 13 0000006f 0
R - 0 0 0
C add_carry_wrap 80 0 00000000
C sub_neg_imm 81 0 00000d55
C and_ones 82 0 00000555
C or_neg 83 0 fffffd55
C xor_ones 84 0 fffffaaa
C sub_from_zero 85 0 ffffffff
C addi_neg 86 0 00000cff
C addi_min_imm 87 0 fffff800
# Load, modify, store, and x0 stays zero
W - 00 24002083 0
W - 01 ff808113 0
W - 02 24202223 0
W - 03 00508013 0
W - 04 24002423 0
W - 05 0000006f 0
W - 90 12345678 0
W - 92 deadbeef 0
R - 0 0 0
C load_source 90 0 12345678
C load_modified 91 0 12345670
C x0_store 92 0 00000000
# Branches and JAL, markers at a0..a5
W - 00 00500093 0
W - 01 00500113 0
W - 02 00700193 0
W - 03 01100213 0
W - 04 00208463 0
W - 05 28402023 0
W - 06 00308463 0
W - 07 28402223 0
W - 08 00309463 0
W - 09 28402423 0
W - 0a 00209463 0
W - 0b 28402623 0
W - 0c 008002ef 0
W - 0d 28402823 0
W - 0e 28502a23 0
W - 0f 0000006f 0
W - a0 0 0
W - a1 0 0
W - a2 0 0
W - a3 0 0
W - a4 0 0
W - a5 0 0
R - 0 0 0
C beq_taken_skip a0 0 00000000
C beq_not_taken a1 0 00000011
C bne_taken_skip a2 0 00000000
C bne_not_taken a3 0 00000011
C jal_skip a4 0 00000000
C jal_link a5 0 00000034
# Host read while the branch program runs, then a read while halted
P read_while_running 90 0 12345678
C read_while_halted f1 0 0f0f0f0f
